//--- sim.f
+incdir+logic
+incdir+tests
logic/sparc_isa_pkg.sv
logic/cu_ctrl_pkg.sv
logic/instr_class_decode.sv
logic/microsequencer.sv
logic/control_word_rom.sv
logic/control_unit.sv
tests/control_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= control_unit_tb
FLAGS     ?= --binary --timing --assert -j 0
SEED      ?= 41738
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/cu_tb_model.svh
`ifndef CU_TB_MODEL_SVH
`define CU_TB_MODEL_SVH

// instruction class from the op, op2 and op3 fields
function automatic instr_class_t ref_class(input logic [31:0] w);
	logic [1:0] op;
	logic [2:0] op2;
	logic [5:0] op3;
	logic [5:0] base;
	instr_class_t c;
	op   = w[`IR_OP_HI:`IR_OP_LO];
	op2  = w[`IR_OP2_HI:`IR_OP2_LO];
	op3  = w[`IR_OP3_HI:`IR_OP3_LO];
	base = op3 & 6'b101111;
	c    = IC_ILLEGAL;
	if (op == 2'b01) begin
		c = IC_CALL;
	end else if (op == 2'b00) begin
		if (op2 == 3'b100)
			c = IC_SETHI;
		else if (op2 == 3'b010)
			c = IC_BRANCH;
	end else if (op == 2'b10) begin
		// add addx sub subx and andn or orn xor xnor
		if (base inside {6'h00, 6'h08, 6'h04, 6'h0c, 6'h01, 6'h05, 6'h02, 6'h06, 6'h03, 6'h07})
			c = op3[4] ? IC_ALU_CC : IC_ALU;
		else if (op3 inside {6'h25, 6'h26, 6'h27})
			c = IC_ALU;
		else if (op3 == 6'h38)
			c = IC_JMPL;
	end else begin
		if (op3 inside {6'h01, 6'h02, 6'h03, 6'h08, 6'h09, 6'h0a, 6'h0d})
			c = IC_LOAD;
		else if (op3 inside {6'h04, 6'h05, 6'h06, 6'h07, 6'h0f})
			c = IC_STORE;
	end
	return c;
endfunction

function automatic cu_state_t ref_next_state(input cu_state_t s, input instr_class_t cls,
		input logic imm, input logic annul, input logic bc, input logic mc);
	cu_state_t n;
	case (s)
		RESET:  n = FETCH0;
		FETCH0: n = FETCH1;
		FETCH1: n = FETCH2;
		FETCH2: n = mc ? DECODE : FETCH2;
		DECODE: begin
			case (cls)
				IC_ALU:    n = imm ? ALU_IMM : ALU_REG;
				IC_ALU_CC: n = imm ? ALU_CC_IMM : ALU_CC_REG;
				IC_SETHI:  n = SETHI_WR;
				IC_LOAD:   n = imm ? LD_ADDR_IMM : LD_ADDR;
				IC_STORE:  n = imm ? ST_ADDR_IMM : ST_ADDR;
				IC_CALL:   n = CALL_LINK;
				IC_JMPL:   n = JMPL_LINK;
				IC_BRANCH: n = bc ? BR_TAKEN0 : (annul ? BR_ANNUL : BR_SKIP);
				default:   n = FETCH0;
			endcase
		end
		LD_ADDR, LD_ADDR_IMM: n = LD_ISSUE;
		LD_ISSUE:             n = LD_WAIT;
		LD_WAIT:              n = mc ? LD_WB : LD_WAIT;
		ST_ADDR, ST_ADDR_IMM: n = ST_DATA;
		ST_DATA:              n = ST_ISSUE;
		ST_ISSUE:             n = ST_WAIT;
		ST_WAIT:              n = mc ? FETCH0 : ST_WAIT;
		CALL_LINK:            n = CALL_JUMP;
		JMPL_LINK:            n = imm ? JMPL_IMM : JMPL_REG;
		BR_TAKEN0:            n = BR_TAKEN1;
		BR_TAKEN1:            n = FETCH1;
		// remaining execute states
		default:              n = FETCH0;
	endcase
	return n;
endfunction

// one line per enable, listing the states that raise it
function automatic load_en_t ref_enables(input cu_state_t s);
	load_en_t e;
	e.ir_ld  = (s == FETCH2);
	e.mar_ld = s inside {FETCH0, BR_TAKEN0, LD_ADDR, LD_ADDR_IMM, ST_ADDR, ST_ADDR_IMM};
	e.mdr_ld = s inside {LD_WAIT, ST_DATA};
	e.pc_ld  = s inside {RESET, FETCH1, CALL_JUMP, JMPL_REG, JMPL_IMM, BR_SKIP, BR_ANNUL};
	e.npc_ld = s inside {RESET, FETCH2, CALL_JUMP, JMPL_REG, JMPL_IMM, BR_TAKEN1, BR_SKIP,
		BR_ANNUL};
	e.fr_ld  = s inside {ALU_CC_REG, ALU_CC_IMM};
	e.rf_wr  = s inside {ALU_REG, ALU_IMM, ALU_CC_REG, ALU_CC_IMM, SETHI_WR, LD_WB, CALL_LINK,
		JMPL_LINK};
	e.rf_clr = (s == RESET);
	return e;
endfunction

`endif

//--- tests/control_unit_tb.sv
`timescale 1ns/100ps
`include "cu_macros.svh"

module control_unit_tb;
	import sparc_isa_pkg::*;
	import cu_ctrl_pkg::*;

	parameter int SEED = 41738;

	logic          Clk;
	logic          Clr;
	logic [31:0]   ir;
	logic          bcond;
	logic          moc;
	cu_state_t     state;
	control_word_t cw;

	logic [15:0] lfsr;
	logic [1:0]  gap;
	logic        pending;
	logic [31:0] next_ir;
	logic        next_bc;
	logic        run_checks;
	cu_state_t   exp_state;

	logic [5:0] alu_codes [13] = '{6'h00, 6'h08, 6'h04, 6'h0c, 6'h01, 6'h05, 6'h02,
		6'h06, 6'h03, 6'h07, 6'h25, 6'h26, 6'h27};
	logic [5:0] ld_codes [7] = '{6'h01, 6'h02, 6'h03, 6'h08, 6'h09, 6'h0a, 6'h0d};
	logic [5:0] st_codes [5] = '{6'h04, 6'h05, 6'h06, 6'h07, 6'h0f};

	`include "cu_tb_model.svh"

	control_unit control_unit_i (
		.Clk   (Clk),
		.Clr   (Clr),
		.ir    (ir),
		.bcond (bcond),
		.moc   (moc),
		.state (state),
		.cw    (cw)
	);

	always #2 Clk = ~Clk;

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s (got %0h, expected %0h)", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "stopped on mismatch");
		end
	endtask

	// advance one clock and load any queued ir and bcond
	// moc goes high after 0 to 3 idle cycles
	task automatic tick();
		logic [31:0] r;
		@(posedge Clk);
		if (gap == 2'd0) begin
			moc <= 1'b1;
			random_bits(2, r);
			gap = r[1:0];
		end else begin
			moc <= 1'b0;
			gap = gap - 2'd1;
		end
		if (pending) begin
			ir      <= next_ir;
			bcond   <= next_bc;
			pending = 1'b0;
		end
		@(negedge Clk);
	endtask

	task automatic wait_for(input cu_state_t target);
		int n;
		n = 0;
		while (state != target) begin
			tick();
			n++;
			if (n > 200) begin
				$display("timeout: state %s not reached within 200 cycles", target.name());
				$display("FAIL: see errors above");
				$fatal(1, "stopped on timeout");
			end
		end
	endtask

	task automatic make_word(input int kind, output logic [31:0] w);
		logic [31:0] s;
		int idx;
		random_bits(32, w);
		random_bits(8, s);
		case (kind)
			0: begin
				if (s[7:6] == 2'b00) begin
					w[31:30] = 2'b00;
					w[24:22] = 3'b100;
				end else begin
					idx = s[3:0] % 13;
					w[31:30] = 2'b10;
					w[24:19] = alu_codes[idx];
					// cc variant of the logic and arithmetic codes
					if (idx < 10)
						w[23] = s[4];
				end
			end
			1: begin
				w[31:30] = 2'b11;
				w[24:19] = s[4] ? ld_codes[s[2:0] % 7] : st_codes[s[2:0] % 5];
			end
			2: begin
				w[31:30] = s[0] ? 2'b01 : 2'b10;
				if (!s[0])
					w[24:19] = 6'h38;
			end
			3: begin
				w[31:30] = 2'b00;
				w[24:22] = 3'b010;
			end
			default: begin
				case (s[1:0])
					2'd0: w[31:22] = {2'b00, w[29:25], 3'b000};
					2'd1: w[31:19] = {2'b11, w[29:25], 6'h00};
					2'd2: w[31:19] = {2'b10, w[29:25], 6'h3f};
					default: w[31:22] = {2'b00, w[29:25], 3'b110};
				endcase
			end
		endcase
	endtask

	task automatic run_instr(input logic [31:0] w, input logic bc);
		cu_state_t exp_exec;
		wait_for(FETCH1);
		next_ir = w;
		next_bc = bc;
		pending = 1'b1;
		wait_for(DECODE);
		exp_exec = ref_next_state(DECODE, ref_class(w), w[`IR_I_BIT], w[`IR_A_BIT], bc, 1'b0);
		tick();
		check({25'b0, state}, {25'b0, exp_exec}, "execute state after DECODE");
	endtask

	// model state follows the DUT one cycle at a time
	always @(negedge Clk) begin
		if (run_checks) begin
			check({25'b0, state}, {25'b0, exp_state}, "state");
			check({24'b0, cw.load}, {24'b0, ref_enables(exp_state)}, "load enables");
			if (exp_state == RESET)
				check({30'b0, cw.mem.r_w, cw.mem.mov}, 32'b0, "memory control in RESET");
			if (exp_state == CALL_LINK)
				check({30'b0, cw.sel.msc}, {30'b0, RD_O7}, "rd select in CALL_LINK");
			if (Clr)
				exp_state = ref_next_state(exp_state, ref_class(ir), ir[`IR_I_BIT],
					ir[`IR_A_BIT], bcond, moc);
			else
				exp_state = RESET;
		end
	end

	initial begin
		logic [31:0] w;
		logic [31:0] r;
		Clk        = 1'b0;
		Clr        = 1'b0;
		ir         = '0;
		bcond      = 1'b0;
		moc        = 1'b0;
		lfsr       = SEED[15:0];
		gap        = 2'd0;
		pending    = 1'b0;
		next_ir    = '0;
		next_bc    = 1'b0;
		run_checks = 1'b0;
		exp_state  = RESET;
		@(posedge Clk);
		run_checks = 1'b1;
		repeat (4) @(posedge Clk);
		Clr <= 1'b1;
		@(negedge Clk);
		wait_for(FETCH2);
		check({31'b0, cw.load.ir_ld}, 32'd1, "ir_ld in FETCH2");
		// alu and sethi, memory, call and jmpl, branches, illegal
		for (int k = 0; k < 5; k++) begin
			for (int j = 0; j < 16; j++) begin
				make_word(k, w);
				random_bits(1, r);
				run_instr(w, r[0]);
			end
		end
		wait_for(FETCH1);
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- logic/control_unit.sv
`timescale 1ns/100ps
`include "cu_macros.svh"

module control_unit (
	input  logic                       Clk,
	input  logic                       Clr,
	input  logic [`IR_W-1:0]           ir,
	input  logic                       bcond,
	input  logic                       moc,
	output cu_ctrl_pkg::cu_state_t     state,
	output cu_ctrl_pkg::control_word_t cw
);
	import sparc_isa_pkg::*;

	instr_info_t info;

	instr_class_decode u_decode (
		.ir   (ir),
		.info (info)
	);

	microsequencer u_seq (
		.Clk   (Clk),
		.Clr   (Clr),
		.info  (info),
		.bcond (bcond),
		.moc   (moc),
		.state (state)
	);

	control_word_rom u_rom (
		.state (state),
		.cw    (cw)
	);

endmodule

//--- logic/control_word_rom.sv
`timescale 1ns/100ps

module control_word_rom (
	input  cu_ctrl_pkg::cu_state_t     state,
	output cu_ctrl_pkg::control_word_t cw
);
	import cu_ctrl_pkg::*;

	// load bits in order ir mar mdr pc _ npc fr rf_wr rf_clr
	// sel bits in order mb _ mm _ mr _ mnp _ mop _ mp _ msa _ msc
	// mem bits in order r_w _ mov _ size
	always_comb begin
		cw = '0;
		case (state)
			RESET:       cw = '{8'b0001_1001, 12'b00_0_1_11_0_00_0_00, 4'b0_0_00, ALU_FROM_IR};
			FETCH0, BR_TAKEN0:
				cw = '{8'b0100_0000, 12'b10_0_0_00_1_11_0_00, 4'b0_0_00, ALU_PASS_B};
			FETCH1:      cw = '{8'b0001_0000, 12'b00_0_0_11_0_11_0_00, 4'b1_1_10, ALU_FROM_IR};
			FETCH2:      cw = '{8'b1000_1000, 12'b00_0_0_11_0_00_0_00, 4'b1_1_10, ALU_FROM_IR};
			DECODE:      cw = '0;
			ALU_REG:     cw = '{8'b0000_0010, 12'b00_0_0_00_0_00_0_00, 4'b0_0_00, ALU_FROM_IR};
			ALU_IMM:     cw = '{8'b0000_0010, 12'b01_0_0_00_0_00_0_00, 4'b0_0_00, ALU_FROM_IR};
			ALU_CC_REG:  cw = '{8'b0000_0110, 12'b00_0_0_00_0_00_0_00, 4'b0_0_00, ALU_FROM_IR};
			ALU_CC_IMM:  cw = '{8'b0000_0110, 12'b01_0_0_00_0_00_0_00, 4'b0_0_00, ALU_FROM_IR};
			SETHI_WR:    cw = '{8'b0000_0010, 12'b10_0_0_00_1_00_0_00, 4'b0_0_00, ALU_FROM_IR};
			LD_ADDR:     cw = '{8'b0100_0000, 12'b00_0_0_00_1_00_0_00, 4'b1_0_00, ALU_FROM_IR};
			LD_ADDR_IMM: cw = '{8'b0100_0000, 12'b01_0_0_00_1_00_0_00, 4'b1_0_00, ALU_FROM_IR};
			LD_ISSUE:    cw = '{8'b0000_0000, 12'b00_0_0_00_0_00_0_00, 4'b1_1_00, ALU_FROM_IR};
			LD_WAIT:     cw = '{8'b0010_0000, 12'b00_0_0_00_0_00_0_00, 4'b1_1_00, ALU_FROM_IR};
			// mdr through the alu into the register file
			LD_WB:       cw = '{8'b0000_0010, 12'b11_0_0_00_1_00_0_00, 4'b0_0_00, ALU_PASS_B};
			ST_ADDR:     cw = '{8'b0100_0000, 12'b00_1_0_00_1_00_0_00, 4'b1_0_00, ALU_FROM_IR};
			ST_ADDR_IMM: cw = '{8'b0100_0000, 12'b01_1_0_00_1_00_0_00, 4'b1_0_00, ALU_FROM_IR};
			// rd on port a for the store data
			ST_DATA:     cw = '{8'b0010_0000, 12'b00_1_0_00_1_00_1_00, 4'b0_0_00, ALU_PASS_A};
			ST_ISSUE, ST_WAIT:
				cw = '{8'b0000_0000, 12'b00_0_0_00_0_00_0_00, 4'b0_1_00, ALU_FROM_IR};
			// link pc into o7
			CALL_LINK:   cw = '{8'b0000_0010, 12'b10_0_0_00_1_00_0_01, 4'b0_0_00, ALU_PASS_B};
			CALL_JUMP:   cw = '{8'b0001_1000, 12'b00_0_0_10_0_11_0_00, 4'b0_0_00, ALU_FROM_IR};
			JMPL_LINK:   cw = '{8'b0000_0010, 12'b10_0_0_00_1_00_0_00, 4'b0_0_00, ALU_PASS_B};
			JMPL_REG:    cw = '{8'b0001_1000, 12'b00_0_0_00_0_11_0_00, 4'b0_0_00, ALU_FROM_IR};
			JMPL_IMM:    cw = '{8'b0001_1000, 12'b01_0_0_00_0_11_0_00, 4'b0_0_00, ALU_FROM_IR};
			BR_TAKEN1:   cw = '{8'b0000_1000, 12'b00_0_0_10_0_11_0_00, 4'b0_0_00, ALU_FROM_IR};
			BR_SKIP:     cw = '{8'b0001_1000, 12'b00_0_0_11_0_11_0_00, 4'b0_0_00, ALU_FROM_IR};
			// annul skips the delay slot
			BR_ANNUL:    cw = '{8'b0001_1000, 12'b00_0_0_01_0_10_0_00, 4'b0_0_00, ALU_FROM_IR};
			default:     cw = '0;
		endcase
	end

	// mar and ir share the bus cycle
	always_comb begin
		a_ir_mar_excl: assert (!(cw.load.ir_ld && cw.load.mar_ld))
			else $error("ir_ld and mar_ld both active in state %0d", state);
	end

endmodule

//--- logic/microsequencer.sv
`timescale 1ns/100ps

module microsequencer (
	input  logic                       Clk,
	input  logic                       Clr,
	input  sparc_isa_pkg::instr_info_t info,
	input  logic                       bcond,
	input  logic                       moc,
	output cu_ctrl_pkg::cu_state_t     state
);
	import sparc_isa_pkg::*;
	import cu_ctrl_pkg::*;

	cu_state_t next_state;
	logic      state_known;
	logic      in_wait;

	always_ff @(posedge Clk, negedge Clr) begin
		if (!Clr)
			state <= RESET;
		else
			state <= next_state;
	end

	always_comb begin
		next_state  = RESET;
		state_known = 1'b1;
		case (state)
			RESET:  next_state = FETCH0;
			FETCH0: next_state = FETCH1;
			FETCH1: next_state = FETCH2;
			FETCH2: next_state = moc ? DECODE : FETCH2;
			DECODE: begin
				case (info.iclass)
					IC_ALU:    next_state = info.imm ? ALU_IMM : ALU_REG;
					IC_ALU_CC: next_state = info.imm ? ALU_CC_IMM : ALU_CC_REG;
					IC_SETHI:  next_state = SETHI_WR;
					IC_LOAD:   next_state = info.imm ? LD_ADDR_IMM : LD_ADDR;
					IC_STORE:  next_state = info.imm ? ST_ADDR_IMM : ST_ADDR;
					IC_CALL:   next_state = CALL_LINK;
					IC_JMPL:   next_state = JMPL_LINK;
					IC_BRANCH: begin
						if (bcond)
							next_state = BR_TAKEN0;
						else
							next_state = info.annul ? BR_ANNUL : BR_SKIP;
					end
					default:   next_state = FETCH0;
				endcase
			end
			LD_ADDR, LD_ADDR_IMM: next_state = LD_ISSUE;
			LD_ISSUE:             next_state = LD_WAIT;
			LD_WAIT:              next_state = moc ? LD_WB : LD_WAIT;
			ST_ADDR, ST_ADDR_IMM: next_state = ST_DATA;
			ST_DATA:              next_state = ST_ISSUE;
			ST_ISSUE:             next_state = ST_WAIT;
			ST_WAIT:              next_state = moc ? FETCH0 : ST_WAIT;
			CALL_LINK:            next_state = CALL_JUMP;
			JMPL_LINK:            next_state = info.imm ? JMPL_IMM : JMPL_REG;
			BR_TAKEN0:            next_state = BR_TAKEN1;
			// taken branch already holds the new pc in mar
			BR_TAKEN1:            next_state = FETCH1;
			ALU_REG, ALU_IMM, ALU_CC_REG, ALU_CC_IMM, SETHI_WR, LD_WB,
			CALL_JUMP, JMPL_REG, JMPL_IMM, BR_SKIP, BR_ANNUL:
				next_state = FETCH0;
			default: begin
				next_state  = RESET;
				state_known = 1'b0;
			end
		endcase
	end

	assign in_wait = state inside {FETCH2, LD_WAIT, ST_WAIT};

	// decode always dispatches
	a_decode_once: assert property (@(posedge Clk) disable iff (!Clr)
		state == DECODE |=> state != DECODE);

	a_reset_exit: assert property (@(posedge Clk)
		$rose(Clr) |=> state_known);

	// memory waits end only on moc
	a_wait_moc: assert property (@(posedge Clk) disable iff (!Clr)
		in_wait && !moc |=> $stable(state));

endmodule

//--- logic/instr_class_decode.sv
`timescale 1ns/100ps
`include "cu_macros.svh"

module instr_class_decode (
	input  logic [`IR_W-1:0]           ir,
	output sparc_isa_pkg::instr_info_t info
);
	import sparc_isa_pkg::*;

	op_t               op;
	logic [2:0]        op2;
	logic [`OP3_W-1:0] op3;
	logic [`OP3_W-1:0] op3_base;
	logic              is_alu_base;
	instr_class_t      cls;

	assign op  = op_t'(ir[`IR_OP_HI:`IR_OP_LO]);
	assign op2 = ir[`IR_OP2_HI:`IR_OP2_LO];
	assign op3 = ir[`IR_OP3_HI:`IR_OP3_LO];

	// strip the cc bit
	assign op3_base = {op3[5], 1'b0, op3[3:0]};
	assign is_alu_base = op3_base inside {OP3_ADD, OP3_ADDX, OP3_SUB, OP3_SUBX,
		OP3_AND, OP3_ANDN, OP3_OR, OP3_ORN, OP3_XOR, OP3_XNOR};

	always_comb begin
		cls = IC_ILLEGAL;
		case (op)
			CALL_FMT:
				cls = IC_CALL;
			BRANCH_FMT:
				if (op2 == OP2_SETHI)
					cls = IC_SETHI;
				else if (op2 == OP2_BICC)
					cls = IC_BRANCH;
			ARITH_FMT:
				if (is_alu_base)
					cls = op3[4] ? IC_ALU_CC : IC_ALU;
				else if (op3 inside {OP3_SLL, OP3_SRL, OP3_SRA})
					cls = IC_ALU;
				else if (op3 == OP3_JMPL)
					cls = IC_JMPL;
			MEM_FMT:
				if (op3 inside {OP3_LDSB, OP3_LDSH, OP3_LDSW, OP3_LDUB, OP3_LDUH,
						OP3_LDD, OP3_LDSTUB})
					cls = IC_LOAD;
				else if (op3 inside {OP3_STB, OP3_STH, OP3_ST, OP3_STD, OP3_SWAP})
					cls = IC_STORE;
			default:
				cls = IC_ILLEGAL;
		endcase
	end

	assign info.iclass = cls;
	assign info.imm    = ir[`IR_I_BIT];
	assign info.annul  = ir[`IR_A_BIT];

endmodule

//--- logic/cu_ctrl_pkg.sv
`include "cu_macros.svh"

package cu_ctrl_pkg;

	typedef enum logic [`CU_STATE_W-1:0] {
		RESET       = 7'd0,
		FETCH0      = 7'd1,
		FETCH1      = 7'd2,
		FETCH2      = 7'd3,
		DECODE      = 7'd4,
		ALU_REG     = 7'd10,
		ALU_IMM     = 7'd11,
		ALU_CC_REG  = 7'd12,
		ALU_CC_IMM  = 7'd13,
		SETHI_WR    = 7'd14,
		LD_ADDR     = 7'd20,
		LD_ISSUE    = 7'd21,
		LD_WAIT     = 7'd22,
		LD_WB       = 7'd23,
		ST_ADDR     = 7'd25,
		ST_DATA     = 7'd26,
		ST_ISSUE    = 7'd27,
		ST_WAIT     = 7'd28,
		LD_ADDR_IMM = 7'd30,
		ST_ADDR_IMM = 7'd35,
		CALL_LINK   = 7'd40,
		CALL_JUMP   = 7'd41,
		JMPL_LINK   = 7'd42,
		JMPL_REG    = 7'd43,
		JMPL_IMM    = 7'd44,
		BR_TAKEN0   = 7'd49,
		BR_TAKEN1   = 7'd50,
		BR_SKIP     = 7'd51,
		BR_ANNUL    = 7'd52
	} cu_state_t;

	// with ALU_FROM_IR the datapath decodes op3
	typedef enum logic [5:0] {
		ALU_FROM_IR = 6'b000000,
		ALU_PASS_A  = 6'b100000,
		ALU_PASS_B  = 6'b100001
	} alu_op_t;

	typedef enum logic [1:0] {
		RD_FROM_IR = 2'b00,
		RD_O7      = 2'b01
	} rd_sel_t;

	typedef struct packed {
		logic ir_ld;
		logic mar_ld;
		logic mdr_ld;
		logic pc_ld;
		logic npc_ld;
		logic fr_ld;
		logic rf_wr;
		logic rf_clr;
	} load_en_t;

	typedef struct packed {
		logic [1:0] mb;
		logic       mm;
		logic       mr;
		logic [1:0] mnp;
		logic       mop;
		logic [1:0] mp;
		logic       msa;
		rd_sel_t    msc;
	} mux_sel_t;

	typedef struct packed {
		logic       r_w;
		logic       mov;
		logic [1:0] size;
	} mem_ctrl_t;

	typedef struct packed {
		load_en_t  load;
		mux_sel_t  sel;
		mem_ctrl_t mem;
		alu_op_t   alu_op;
	} control_word_t;

endpackage

//--- logic/sparc_isa_pkg.sv
`include "cu_macros.svh"

package sparc_isa_pkg;

	typedef enum logic [1:0] {
		BRANCH_FMT = 2'b00,
		CALL_FMT   = 2'b01,
		ARITH_FMT  = 2'b10,
		MEM_FMT    = 2'b11
	} op_t;

	// op2 for op = 00
	typedef enum logic [2:0] {
		OP2_BICC  = 3'b010,
		OP2_SETHI = 3'b100
	} op2_t;

	// arithmetic op3 codes whose cc variants set bit 4
	typedef enum logic [`OP3_W-1:0] {
		OP3_ADD  = 6'b000000,
		OP3_AND  = 6'b000001,
		OP3_OR   = 6'b000010,
		OP3_XOR  = 6'b000011,
		OP3_SUB  = 6'b000100,
		OP3_ANDN = 6'b000101,
		OP3_ORN  = 6'b000110,
		OP3_XNOR = 6'b000111,
		OP3_ADDX = 6'b001000,
		OP3_SUBX = 6'b001100,
		OP3_SLL  = 6'b100101,
		OP3_SRL  = 6'b100110,
		OP3_SRA  = 6'b100111,
		OP3_JMPL = 6'b111000
	} alu_op3_t;

	// memory op3 codes overlap the arithmetic ones
	typedef enum logic [`OP3_W-1:0] {
		OP3_LDUB   = 6'b000001,
		OP3_LDUH   = 6'b000010,
		OP3_LDD    = 6'b000011,
		OP3_ST     = 6'b000100,
		OP3_STB    = 6'b000101,
		OP3_STH    = 6'b000110,
		OP3_STD    = 6'b000111,
		OP3_LDSW   = 6'b001000,
		OP3_LDSB   = 6'b001001,
		OP3_LDSH   = 6'b001010,
		OP3_LDSTUB = 6'b001101,
		OP3_SWAP   = 6'b001111
	} mem_op3_t;

	typedef enum logic [3:0] {
		IC_ALU,
		IC_ALU_CC,
		IC_SETHI,
		IC_LOAD,
		IC_STORE,
		IC_CALL,
		IC_JMPL,
		IC_BRANCH,
		IC_ILLEGAL
	} instr_class_t;

	typedef struct packed {
		instr_class_t iclass;
		logic         imm;
		logic         annul;
	} instr_info_t;

endpackage

//--- logic/cu_macros.svh
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

// widths
`define CU_STATE_W 7
`define IR_W 32
`define OP3_W 6
`define COND_W 4

// field positions in a 32-bit instruction word
`define IR_OP_HI 31
`define IR_OP_LO 30
`define IR_A_BIT 29
`define IR_COND_HI 28
`define IR_COND_LO 25
`define IR_OP2_HI 24
`define IR_OP2_LO 22
`define IR_OP3_HI 24
`define IR_OP3_LO 19
`define IR_I_BIT 13

`endif
